// File: src/udp_rx_pkg.sv
package udp_rx_pkg;

	// ********************
	// basic types
	// ********************
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] byte_len_t;

	// one byte of a stream, no back-pressure
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       last;   // final byte of the stream
	} byte_beat_t;

	// single-cycle length announcement
	typedef struct packed {
		logic      valid;
		byte_len_t len;
	} len_msg_t;

	// ********************
	// protocol constants
	// ********************
	localparam logic [7:0]  preamble_byte = 8'h55;
	localparam logic [7:0]  sfd_byte      = 8'hd5;
	localparam logic [5:0]  preamble_len  = 6'd7;     // 0x55 bytes before the sfd
	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam logic [7:0]  ip_proto_udp  = 8'd17;
	localparam byte_len_t   udp_head_len  = 16'd8;
	localparam mac_addr_t   broadcast_mac = 48'hff_ff_ff_ff_ff_ff;

	// command layer
	localparam logic [15:0] opcode_cfg   = 16'h0001;
	localparam byte_len_t   cfg_head_len = 16'd4;     // opcode + packet number
	localparam byte_len_t   cmd_head_len = 16'd2;     // opcode only

endpackage

// File: src/gmii_frame_parser.sv
`timescale 1ns/1ps

module gmii_frame_parser import udp_rx_pkg::*; #(
	parameter mac_addr_t board_mac = 48'h00_11_22_33_44_55,
	parameter ip_addr_t  board_ip  = {8'd192, 8'd168, 8'd1, 8'd10}
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       gmii_rx_dv,
	input  logic [7:0] gmii_rxd,
	output byte_beat_t pay_beat,
	output len_msg_t   pay_len
);

	// one-hot frame states
	typedef enum logic [6:0] {
		st_idle     = 7'b000_0001,
		st_preamble = 7'b000_0010,
		st_eth_head = 7'b000_0100,
		st_ip_head  = 7'b000_1000,
		st_udp_head = 7'b001_0000,
		st_payload  = 7'b010_0000,
		st_wait_end = 7'b100_0000
	} state_t;

	state_t      state;
	logic [5:0]  cnt;           // byte index inside the current header
	mac_addr_t   dst_mac;
	logic [15:0] eth_type;
	logic [3:0]  ip_ihl;        // ip header length in 32-bit words
	logic [7:0]  ip_proto;
	ip_addr_t    dst_ip;
	byte_len_t   udp_len;
	byte_len_t   pay_left;      // payload bytes still to come

	logic [5:0]  ip_last;
	logic        mac_ok;
	logic        has_pay;
	byte_len_t   pay_size;

	// index of the final ip header byte, options included
	assign ip_last  = {ip_ihl, 2'b00} - 6'd1;
	assign mac_ok   = (dst_mac == board_mac) || (dst_mac == broadcast_mac);
	assign pay_size = udp_len - udp_head_len;
	assign has_pay  = udp_len > udp_head_len;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			cnt      <= '0;
			dst_mac  <= '0;
			eth_type <= '0;
			ip_ihl   <= '0;
			ip_proto <= '0;
			dst_ip   <= '0;
			udp_len  <= '0;
			pay_left <= '0;
			pay_beat <= '0;
			pay_len  <= '0;
		end else begin
			pay_beat.valid <= 1'b0;
			pay_beat.last  <= 1'b0;
			pay_len.valid  <= 1'b0;

			case (state)
				st_idle: begin
					if (gmii_rx_dv) begin
						cnt   <= 6'd1;    // first preamble byte consumed here
						state <= (gmii_rxd == preamble_byte) ? st_preamble : st_wait_end;
					end
				end

				st_preamble: begin
					if (gmii_rx_dv) begin
						cnt <= cnt + 6'd1;
						if (cnt == preamble_len) begin
							cnt   <= '0;
							state <= (gmii_rxd == sfd_byte) ? st_eth_head : st_wait_end;
						end else if (gmii_rxd != preamble_byte) begin
							state <= st_wait_end;
						end
					end
				end

				// ********************
				// ethernet header, 14 bytes
				// ********************
				st_eth_head: begin
					if (gmii_rx_dv) begin
						cnt <= cnt + 6'd1;
						if (cnt < 6'd6) begin
							dst_mac <= {dst_mac[39:0], gmii_rxd};
						end else if (cnt >= 6'd12) begin
							eth_type <= {eth_type[7:0], gmii_rxd};
						end
						if (cnt == 6'd13) begin
							cnt   <= '0;
							state <= st_ip_head;
						end
					end
				end

				// mac and ethertype get checked on the first ip byte
				st_ip_head: begin
					if (gmii_rx_dv) begin
						cnt <= cnt + 6'd1;
						if (cnt == 6'd0) begin
							ip_ihl <= gmii_rxd[3:0];
							if (!mac_ok || eth_type != eth_type_ipv4 || gmii_rxd[3:0] < 4'd5)
								state <= st_wait_end;
						end else if (cnt == 6'd9) begin
							ip_proto <= gmii_rxd;
						end else if (cnt >= 6'd16 && cnt <= 6'd19) begin
							dst_ip <= {dst_ip[23:0], gmii_rxd};
						end
						if (cnt == ip_last) begin    // option bytes fall through to here
							cnt   <= '0;
							state <= st_udp_head;
						end
					end
				end

				// ********************
				// udp header, 8 bytes
				// ********************
				st_udp_head: begin
					if (gmii_rx_dv) begin
						cnt <= cnt + 6'd1;
						if (cnt == 6'd0 && (ip_proto != ip_proto_udp || dst_ip != board_ip)) begin
							state <= st_wait_end;
						end else if (cnt == 6'd4 || cnt == 6'd5) begin
							udp_len <= {udp_len[7:0], gmii_rxd};
						end else if (cnt == 6'd7) begin
							cnt      <= '0;
							pay_left <= pay_size;
							pay_len  <= '{valid: has_pay, len: pay_size};
							state    <= has_pay ? st_payload : st_wait_end;
						end
					end
				end

				st_payload: begin
					if (gmii_rx_dv) begin
						pay_left <= pay_left - 16'd1;
						pay_beat <= '{valid: 1'b1, data: gmii_rxd, last: pay_left == 16'd1};
						if (pay_left == 16'd1)
							state <= st_wait_end;
					end
				end

				// fcs and trailing bytes are dropped
				st_wait_end: begin
					if (!gmii_rx_dv)
						state <= st_idle;
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: src/udp_cmd_dispatch.sv
`timescale 1ns/1ps

module udp_cmd_dispatch import udp_rx_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  byte_beat_t pay_beat,
	input  len_msg_t   pay_len,
	output byte_beat_t cfg_beat,
	output len_msg_t   cfg_len,
	output len_msg_t   cfg_pkg_num,
	output byte_beat_t user_beat,
	output len_msg_t   user_len
);

	typedef enum logic [1:0] {
		md_idle,
		md_opcode,    // bytes 0 and 1
		md_cfg,
		md_user
	} mode_t;

	mode_t       mode;
	byte_len_t   len_q;     // payload length announced by the parser
	byte_len_t   idx;       // index of the incoming payload byte
	logic [7:0]  op_hi;
	logic [7:0]  pkg_hi;
	logic [15:0] opcode;

	// opcode is big-endian, complete on byte 1
	assign opcode = {op_hi, pay_beat.data};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode        <= md_idle;
			len_q       <= '0;
			idx         <= '0;
			op_hi       <= '0;
			pkg_hi      <= '0;
			cfg_beat    <= '0;
			cfg_len     <= '0;
			cfg_pkg_num <= '0;
			user_beat   <= '0;
			user_len    <= '0;
		end else begin
			cfg_beat.valid    <= 1'b0;
			cfg_beat.last     <= 1'b0;
			user_beat.valid   <= 1'b0;
			user_beat.last    <= 1'b0;
			cfg_len.valid     <= 1'b0;
			cfg_pkg_num.valid <= 1'b0;
			user_len.valid    <= 1'b0;

			if (pay_len.valid) begin
				// a new payload always restarts the decode
				len_q <= pay_len.len;
				idx   <= '0;
				mode  <= md_opcode;
			end else if (pay_beat.valid) begin
				idx <= idx + 16'd1;
				case (mode)
					md_opcode: begin
						if (idx == 16'd0) begin
							op_hi <= pay_beat.data;
							if (pay_beat.last)
								mode <= md_idle;    // no room for an opcode
						end else if (opcode != opcode_cfg) begin
							user_len <= '{valid: 1'b1, len: len_q - cmd_head_len};
							mode     <= pay_beat.last ? md_idle : md_user;
						end else if (len_q >= cfg_head_len) begin
							cfg_len <= '{valid: 1'b1, len: len_q - cfg_head_len};
							mode    <= md_cfg;
						end else begin
							mode <= md_idle;    // cfg packet too short for its number
						end
					end

					// ********************
					// configuration packet
					// ********************
					md_cfg: begin
						if (idx == 16'd2) begin
							pkg_hi <= pay_beat.data;
						end else if (idx == 16'd3) begin
							cfg_pkg_num <= '{valid: 1'b1, len: {pkg_hi, pay_beat.data}};
						end else begin
							cfg_beat <= pay_beat;    // stream from byte 4 on
						end
						if (pay_beat.last)
							mode <= md_idle;
					end

					md_user: begin
						user_beat <= pay_beat;
						if (pay_beat.last)
							mode <= md_idle;
					end

					default: mode <= md_idle;    // stray beats outside a payload
				endcase
			end
		end
	end

endmodule

// File: src/udp_rx_top.sv
`timescale 1ns/1ps

module udp_rx_top import udp_rx_pkg::*; #(
	parameter mac_addr_t board_mac = 48'h00_11_22_33_44_55,
	parameter ip_addr_t  board_ip  = {8'd192, 8'd168, 8'd1, 8'd10}
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       gmii_rx_dv,
	input  logic [7:0] gmii_rxd,
	output byte_beat_t cfg_beat,
	output len_msg_t   cfg_len,
	output len_msg_t   cfg_pkg_num,
	output byte_beat_t user_beat,
	output len_msg_t   user_len
);

	// udp payload between the two stages
	byte_beat_t pay_beat;
	len_msg_t   pay_len;

	gmii_frame_parser #(
		.board_mac (board_mac),
		.board_ip  (board_ip)
	) u_gmii_frame_parser (
		.clk        (clk),
		.rst_n      (rst_n),
		.gmii_rx_dv (gmii_rx_dv),
		.gmii_rxd   (gmii_rxd),
		.pay_beat   (pay_beat),
		.pay_len    (pay_len)
	);

	udp_cmd_dispatch u_udp_cmd_dispatch (
		.clk         (clk),
		.rst_n       (rst_n),
		.pay_beat    (pay_beat),
		.pay_len     (pay_len),
		.cfg_beat    (cfg_beat),
		.cfg_len     (cfg_len),
		.cfg_pkg_num (cfg_pkg_num),
		.user_beat   (user_beat),
		.user_len    (user_len)
	);

endmodule

// File: dv/udp_rx_properties.sv
`timescale 1ns/1ps

module udp_rx_properties import udp_rx_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input byte_beat_t cfg_beat,
	input len_msg_t   cfg_len,
	input byte_beat_t user_beat,
	input len_msg_t   user_len
);

	logic cfg_open;     // cfg length seen, stream not closed yet
	logic user_open;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_open  <= 1'b0;
			user_open <= 1'b0;
		end else begin
			if (cfg_len.valid)
				cfg_open <= 1'b1;
			else if (cfg_beat.valid && cfg_beat.last)
				cfg_open <= 1'b0;
			if (user_len.valid)
				user_open <= 1'b1;
			else if (user_beat.valid && user_beat.last)
				user_open <= 1'b0;
		end
	end

	a_one_stream: assert property (@(posedge clk) disable iff (!rst_n)
		!(cfg_beat.valid && user_beat.valid))
		else $error("cfg and user beats valid in the same cycle");

	a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(!cfg_beat.last || cfg_beat.valid) && (!user_beat.last || user_beat.valid))
		else $error("last flag without valid");

	a_cfg_len_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_len.valid |=> !cfg_len.valid)
		else $error("cfg_len valid longer than one cycle");

	a_user_len_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		user_len.valid |=> !user_len.valid)
		else $error("user_len valid longer than one cycle");

	// stream bytes only after their length message
	a_cfg_after_len: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_beat.valid |-> cfg_open)
		else $error("cfg beat without a preceding cfg_len");

	a_user_after_len: assert property (@(posedge clk) disable iff (!rst_n)
		user_beat.valid |-> user_open)
		else $error("user beat without a preceding user_len");

endmodule

bind udp_cmd_dispatch udp_rx_properties u_udp_rx_properties (
	.clk       (clk),
	.rst_n     (rst_n),
	.cfg_beat  (cfg_beat),
	.cfg_len   (cfg_len),
	.user_beat (user_beat),
	.user_len  (user_len)
);

// File: dv/udp_rx_tb.sv
`timescale 1ns/1ps

module udp_rx_tb import udp_rx_pkg::*; ();

	localparam int          num_frames  = 14;
	localparam int          drain_limit = 200;    // cycles to wait for a frame's outputs
	localparam mac_addr_t   own_mac = 48'h00_11_22_33_44_55;
	localparam mac_addr_t   bc_mac  = 48'hff_ff_ff_ff_ff_ff;
	localparam mac_addr_t   bad_mac = 48'h00_11_22_33_44_56;
	localparam mac_addr_t   src_mac = 48'h02_00_00_00_00_01;
	localparam ip_addr_t    own_ip  = {8'd192, 8'd168, 8'd1, 8'd10};
	localparam ip_addr_t    bad_ip  = {8'd192, 8'd168, 8'd1, 8'd11};
	localparam ip_addr_t    src_ip  = {8'd192, 8'd168, 8'd1, 8'd2};
	localparam logic [15:0] et_ip   = 16'h0800;
	localparam logic [15:0] et_arp  = 16'h0806;
	localparam logic [7:0]  pr_udp  = 8'd17;
	localparam logic [7:0]  pr_tcp  = 8'd6;
	localparam logic [15:0] op_cfg  = 16'h0001;
	localparam logic [1:0]  k_drop  = 2'd0;
	localparam logic [1:0]  k_cfg   = 2'd1;
	localparam logic [1:0]  k_usr   = 2'd2;

	typedef struct packed {
		mac_addr_t   dst_mac;
		ip_addr_t    dst_ip;
		logic [15:0] eth_type;
		logic [7:0]  proto;
		logic [3:0]  ihl;
		logic [7:0]  sfd;
		logic [15:0] opcode;
		logic [15:0] pkg_num;
		byte_len_t   pay_len;
		logic [1:0]  kind;
	} frame_t;

	logic       clk;
	logic       rst_n;
	logic       gmii_rx_dv;
	logic [7:0] gmii_rxd;
	byte_beat_t cfg_beat;
	len_msg_t   cfg_len;
	len_msg_t   cfg_pkg_num;
	byte_beat_t user_beat;
	len_msg_t   user_len;

	frame_t     tab [num_frames];
	logic [7:0] frame_q [$];
	logic [8:0] cfg_exp_q [$];     // {data, last}
	logic [8:0] user_exp_q [$];
	byte_len_t  cfg_len_q [$];
	byte_len_t  pkg_num_q [$];
	byte_len_t  user_len_q [$];
	logic [8:0] exp_beat;
	byte_len_t  exp_len;
	integer     seed;

	udp_rx_top u_udp_rx_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.gmii_rx_dv  (gmii_rx_dv),
		.gmii_rxd    (gmii_rxd),
		.cfg_beat    (cfg_beat),
		.cfg_len     (cfg_len),
		.cfg_pkg_num (cfg_pkg_num),
		.user_beat   (user_beat),
		.user_len    (user_len)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got == exp)
		else report_failure($sformatf("error at %0d ns: %s is 0x%0h, expected 0x%0h",
			$time, name, got, exp));
	endtask

	task automatic expect_pending(input string name, input int size);
		assert (size > 0)
		else report_failure($sformatf("unexpected output on %s at %0d ns", name, $time));
	endtask

	function automatic int pending();
		return cfg_exp_q.size() + user_exp_q.size() + cfg_len_q.size()
			+ pkg_num_q.size() + user_len_q.size();
	endfunction

	// ********************
	// frame table
	// ********************
	task automatic load_table();
		//            dst mac  dst ip  type    proto   ihl   sfd    opcode    pkg num   length
		tab[0]  = '{own_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, op_cfg, 16'h0102, 16'd20, k_cfg};
		tab[1]  = '{own_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, 16'h1234, 16'h0, 16'd17, k_usr};
		tab[2]  = '{bc_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, op_cfg, 16'h00ff, 16'd9, k_cfg};
		tab[3]  = '{bc_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, 16'h0042, 16'h0, 16'd6, k_usr};
		tab[4]  = '{bad_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, 16'h0042, 16'h0, 16'd10, k_drop};
		tab[5]  = '{own_mac, bad_ip, et_ip, pr_udp, 4'd5, 8'hd5, 16'h0042, 16'h0, 16'd10, k_drop};
		tab[6]  = '{own_mac, own_ip, et_ip, pr_tcp, 4'd5, 8'hd5, 16'h0042, 16'h0, 16'd10, k_drop};
		tab[7]  = '{own_mac, own_ip, et_arp, pr_udp, 4'd5, 8'hd5, op_cfg, 16'h7, 16'd10, k_drop};
		tab[8]  = '{own_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd4, 16'h0042, 16'h0, 16'd10, k_drop};
		tab[9]  = '{own_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, 16'h0300, 16'h0, 16'd1, k_drop};
		// options present, right after a run of rejected frames
		tab[10] = '{own_mac, own_ip, et_ip, pr_udp, 4'd6, 8'hd5, 16'h0300, 16'h0, 16'd12, k_usr};
		tab[11] = '{own_mac, own_ip, et_ip, pr_udp, 4'd6, 8'hd5, op_cfg, 16'hbeef, 16'd30, k_cfg};
		tab[12] = '{own_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, 16'h0010, 16'h0, 16'd3, k_usr};
		tab[13] = '{own_mac, own_ip, et_ip, pr_udp, 4'd5, 8'hd5, op_cfg, 16'h0203, 16'd5, k_cfg};
	endtask

	task automatic push16(input logic [15:0] v);
		frame_q.push_back(v[15:8]);
		frame_q.push_back(v[7:0]);
	endtask

	// byte stream of one frame plus the outputs it should produce
	task automatic build_frame(input frame_t f);
		int         i;
		int         pay_n;
		logic [7:0] b;
		logic       is_last;
		byte_len_t  ip_total;
		pay_n    = int'(f.pay_len);
		ip_total = 16'({f.ihl, 2'b00}) + udp_head_len + f.pay_len;
		frame_q.delete();
		repeat (7) frame_q.push_back(8'h55);
		frame_q.push_back(f.sfd);
		for (i = 0; i < 6; i++)
			frame_q.push_back(f.dst_mac[47 - 8 * i -: 8]);
		for (i = 0; i < 6; i++)
			frame_q.push_back(src_mac[47 - 8 * i -: 8]);
		push16(f.eth_type);
		frame_q.push_back({4'h4, f.ihl});
		frame_q.push_back(8'h00);
		push16(ip_total);
		push16(16'h1c46);                 // identification
		push16(16'h4000);                 // don't fragment
		frame_q.push_back(8'h40);
		frame_q.push_back(f.proto);
		push16(16'h0000);                 // header checksum, unchecked
		push16(src_ip[31:16]);
		push16(src_ip[15:0]);
		push16(f.dst_ip[31:16]);
		push16(f.dst_ip[15:0]);
		for (i = 0; i < 4 * (int'(f.ihl) - 5); i++)
			frame_q.push_back(8'(i + 1));     // option bytes
		push16(16'd5000);
		push16(16'd1234);
		push16(f.pay_len + udp_head_len);
		push16(16'h0000);

		for (i = 0; i < pay_n; i++) begin
			if (i == 0)
				b = f.opcode[15:8];
			else if (i == 1)
				b = f.opcode[7:0];
			else if (i == 2 && f.opcode == op_cfg)
				b = f.pkg_num[15:8];
			else if (i == 3 && f.opcode == op_cfg)
				b = f.pkg_num[7:0];
			else
				b = 8'($random(seed));
			frame_q.push_back(b);
			is_last = (i == pay_n - 1);
			if (f.kind == k_cfg && i >= 4)
				cfg_exp_q.push_back({b, is_last});
			if (f.kind == k_usr && i >= 2)
				user_exp_q.push_back({b, is_last});
		end
		repeat (4) frame_q.push_back(8'($random(seed)));    // fcs

		if (f.kind == k_cfg) begin
			cfg_len_q.push_back(f.pay_len - 16'd4);
			pkg_num_q.push_back(f.pkg_num);
		end else if (f.kind == k_usr) begin
			user_len_q.push_back(f.pay_len - 16'd2);
		end
	endtask

	task automatic send_frame();
		foreach (frame_q[j]) begin
			@(posedge clk);
			#1;
			gmii_rx_dv = 1'b1;
			gmii_rxd   = frame_q[j];
		end
		@(posedge clk);
		#1;
		gmii_rx_dv = 1'b0;
		gmii_rxd   = 8'h00;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (pending() != 0 && cycles < drain_limit) begin
			@(posedge clk);
			cycles++;
		end
		assert (pending() == 0)
		else report_failure("timeout while waiting for the outputs of a frame");
	endtask

	// ********************
	// output checker
	// ********************
	always @(negedge clk) begin
		if (rst_n) begin
			if (cfg_beat.valid) begin
				expect_pending("cfg_beat", cfg_exp_q.size());
				exp_beat = cfg_exp_q.pop_front();
				compare_value("cfg_beat.data", 16'(cfg_beat.data), 16'(exp_beat[8:1]));
				compare_value("cfg_beat.last", 16'(cfg_beat.last), 16'(exp_beat[0]));
			end
			if (user_beat.valid) begin
				expect_pending("user_beat", user_exp_q.size());
				exp_beat = user_exp_q.pop_front();
				compare_value("user_beat.data", 16'(user_beat.data), 16'(exp_beat[8:1]));
				compare_value("user_beat.last", 16'(user_beat.last), 16'(exp_beat[0]));
			end
			if (cfg_len.valid) begin
				expect_pending("cfg_len", cfg_len_q.size());
				exp_len = cfg_len_q.pop_front();
				compare_value("cfg_len.len", cfg_len.len, exp_len);
			end
			if (cfg_pkg_num.valid) begin
				expect_pending("cfg_pkg_num", pkg_num_q.size());
				exp_len = pkg_num_q.pop_front();
				compare_value("cfg_pkg_num.len", cfg_pkg_num.len, exp_len);
			end
			if (user_len.valid) begin
				expect_pending("user_len", user_len_q.size());
				exp_len = user_len_q.pop_front();
				compare_value("user_len.len", user_len.len, exp_len);
			end
		end
	end

	initial begin
		int n;
		seed       = 53131;
		rst_n      = 1'b0;
		gmii_rx_dv = 1'b0;
		gmii_rxd   = 8'h00;
		load_table();
		repeat (10) @(posedge clk);
		#1;
		assert (!cfg_beat.valid && !cfg_beat.last && !user_beat.valid && !user_beat.last
			&& !cfg_len.valid && !cfg_pkg_num.valid && !user_len.valid)
		else report_failure("a valid or last output is high during reset");
		rst_n = 1'b1;

		for (n = 0; n < num_frames; n++) begin
			build_frame(tab[n]);
			send_frame();
			wait_drain();
			repeat (12) @(posedge clk);    // inter-frame gap
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// File: filelist.f
src/udp_rx_pkg.sv
src/gmii_frame_parser.sv
src/udp_cmd_dispatch.sv
src/udp_rx_top.sv
dv/udp_rx_properties.sv
dv/udp_rx_tb.sv

// File: Makefile
# Verilator build and run of the UDP receive testbench

VERILATOR ?= verilator
TOP       ?= udp_rx_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
